// ==== Bender.yml ====
package:
  name: h264_fetch

sources:
  # packages first, modules import them
  - verilog/mb_geom_pkg.sv
  - verilog/fetch_ctrl_pkg.sv
  - verilog/mb_word_source.sv
  - verilog/word_fifo.sv
  - verilog/fetch.sv
  - verilog/h264_fetch_top.sv
  - target: test
    files:
      - bench/tb_h264_fetch.sv

// ==== bench/tb_h264_fetch.sv ====
`timescale 1ns/1ps

module tb_h264_fetch
    import mb_geom_pkg::*, fetch_ctrl_pkg::*;
();

    // small frame, 3x2 macroblocks
    localparam int WIDTH_MB   = 3;
    localparam int HEIGHT_MB  = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_MB     = WIDTH_MB * HEIGHT_MB;
    localparam int MEM_WORDS  = NUM_MB * WORDS_PER_MB;
    localparam int TIMEOUT    = 2000;

    logic      clk;
    logic      rst;
    logic      en_i;
    logic      mem_req_o;
    mem_addr_t mem_addr_o;
    mem_word_t mem_rdata_i;
    logic      mb_valid_o;
    mb_coord_t mb_x_o;
    mb_coord_t mb_y_o;
    logic      mb_ack_i;
    row_idx_t  row_sel_i;
    pix_row_t  row_o;
    logic      frame_done_o;

    // frame memory model
    mem_word_t frame_mem [MEM_WORDS];
    logic      req_q;
    mem_addr_t addr_q;
    int        req_count;
    integer    seed;

    h264_fetch_top #(
        .WIDTH_MB   (WIDTH_MB),
        .HEIGHT_MB  (HEIGHT_MB),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) h264_fetch_top_i (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .mb_valid_o   (mb_valid_o),
        .mb_x_o       (mb_x_o),
        .mb_y_o       (mb_y_o),
        .mb_ack_i     (mb_ack_i),
        .row_sel_i    (row_sel_i),
        .row_o        (row_o),
        .frame_done_o (frame_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // request sampled mid cycle, counted for the read checks
    always @(negedge clk) begin
        req_q  = mem_req_o;
        addr_q = mem_addr_o;
        if (mem_req_o === 1'b1) begin
            req_count = req_count + 1;
            if (int'(mem_addr_o) >= MEM_WORDS) begin
                report_failure($sformatf("frame memory read outside the frame at %0d",
                                         mem_addr_o));
            end
        end
    end

    // read data one cycle after the request
    always @(posedge clk) begin
        #1;
        if (req_q === 1'b1) begin
            mem_rdata_i = frame_mem[addr_q];
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic compare_row(input string name, input pix_row_t exp, input pix_row_t got);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t: %s expected %h got %h",
                                     $time, name, exp, got));
        end
    endtask

    task automatic compare_coord(input string name, input mb_coord_t exp, input mb_coord_t got);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t: %s expected %0d got %0d",
                                     $time, name, exp, got));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %0t: %s expected %b got %b",
                                     $time, name, exp, got));
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // luma row y of macroblock (mx, my) straight from the memory layout
    function automatic pix_row_t expected_row(input int mx, input int my, input int y);
        pix_row_t  row;
        mem_word_t w;
        for (int x = 0; x < MB_SIZE; x++) begin
            w = frame_mem[(my * WIDTH_MB + mx) * WORDS_PER_MB + y * PIX_PER_WORD
                          + x / PIX_PER_WORD];
            row[x*PIXEL_W +: PIXEL_W] = w[(x % PIX_PER_WORD)*PIXEL_W +: PIXEL_W];
        end
        return row;
    endfunction

    task automatic wait_mb_valid();
        int cycles;
        cycles = 0;
        while (mb_valid_o !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                report_failure("timeout waiting for mb_valid_o");
            end
            next_cycle();
            cycles++;
        end
    endtask

    // walk all 16 rows through row_sel_i
    task automatic check_rows(input int mx, input int my);
        for (int r = 0; r < MB_SIZE; r++) begin
            row_sel_i = row_idx_t'(r);
            @(negedge clk);
            compare_row($sformatf("row_o[%0d]", r), expected_row(mx, my, r), row_o);
            next_cycle();
        end
    endtask

    // one ack cycle, then valid drops and coordinates step in raster order
    task automatic ack_and_check(input int mx, input int my, input logic last);
        int next_idx;
        // raster index of the following macroblock
        next_idx = my * WIDTH_MB + mx + 1;
        mb_ack_i = 1'b1;
        next_cycle();
        mb_ack_i = 1'b0;
        compare_flag("mb_valid_o", 1'b0, mb_valid_o);
        compare_flag("frame_done_o", last, frame_done_o);
        compare_coord("mb_x_o", mb_coord_t'(next_idx % WIDTH_MB), mb_x_o);
        compare_coord("mb_y_o", mb_coord_t'(next_idx / WIDTH_MB), mb_y_o);
    endtask

    task automatic test_reset();
        compare_flag("mb_valid_o", 1'b0, mb_valid_o);
        compare_flag("frame_done_o", 1'b0, frame_done_o);
        compare_flag("mem_req_o", 1'b0, mem_req_o);
        compare_coord("mb_x_o", '0, mb_x_o);
        compare_coord("mb_y_o", '0, mb_y_o);
    endtask

    task automatic test_enable_hold();
        int start_count;
        start_count = req_count;
        repeat (20) begin
            next_cycle();
            compare_flag("mb_valid_o", 1'b0, mb_valid_o);
        end
        if (req_count != start_count) begin
            report_failure("frame memory read while en_i was low");
        end
        en_i = 1'b1;
        wait_mb_valid();
    endtask

    task automatic test_first_mb();
        compare_coord("mb_x_o", '0, mb_x_o);
        compare_coord("mb_y_o", '0, mb_y_o);
        // exactly one macroblock of reads so far
        if (req_count != WORDS_PER_MB) begin
            report_failure($sformatf("first macroblock took %0d reads instead of 64",
                                     req_count));
        end
        check_rows(0, 0);
    endtask

    task automatic test_ack_backpressure();
        int start_count;
        start_count = req_count;
        for (int c = 0; c < 50; c++) begin
            row_sel_i = row_idx_t'(c % MB_SIZE);
            @(negedge clk);
            compare_flag("mb_valid_o", 1'b1, mb_valid_o);
            compare_coord("mb_x_o", '0, mb_x_o);
            compare_coord("mb_y_o", '0, mb_y_o);
            compare_row($sformatf("row_o[%0d]", c % MB_SIZE),
                        expected_row(0, 0, c % MB_SIZE), row_o);
            next_cycle();
        end
        if (req_count != start_count) begin
            report_failure("frame memory read while the macroblock was held");
        end
        ack_and_check(0, 0, 1'b0);
    endtask

    task automatic test_full_frame();
        int mx;
        int my;
        int delay;
        int start_count;
        for (int mb = 1; mb < NUM_MB; mb++) begin
            mx = mb % WIDTH_MB;
            my = mb / WIDTH_MB;
            wait_mb_valid();
            compare_coord("mb_x_o", mb_coord_t'(mx), mb_x_o);
            compare_coord("mb_y_o", mb_coord_t'(my), mb_y_o);
            if (req_count != (mb + 1) * WORDS_PER_MB) begin
                report_failure($sformatf("read count %0d wrong after macroblock %0d",
                                         req_count, mb));
            end
            check_rows(mx, my);
            // intra stage takes 0 to 7 cycles to accept
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) next_cycle();
            compare_flag("mb_valid_o", 1'b1, mb_valid_o);
            ack_and_check(mx, my, mb == NUM_MB - 1);
        end
        // frame over, nothing more may be read
        start_count = req_count;
        repeat (20) begin
            next_cycle();
            compare_flag("frame_done_o", 1'b1, frame_done_o);
            compare_flag("mb_valid_o", 1'b0, mb_valid_o);
        end
        if (req_count != start_count) begin
            report_failure("frame memory read after frame done");
        end
    endtask

    initial begin
        seed        = 27;
        rst         = 1'b1;
        en_i        = 1'b0;
        mb_ack_i    = 1'b0;
        row_sel_i   = '0;
        mem_rdata_i = '0;
        req_q       = 1'b0;
        addr_q      = '0;
        req_count   = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            frame_mem[a] = $random(seed);
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_enable_hold();
        test_first_mb();
        test_ack_backpressure();
        test_full_frame();
        $display("Result: PASSED");
        $finish;
    end

endmodule : tb_h264_fetch

// ==== files.f ====
verilog/mb_geom_pkg.sv
verilog/fetch_ctrl_pkg.sv
verilog/mb_word_source.sv
verilog/word_fifo.sv
verilog/fetch.sv
verilog/h264_fetch_top.sv
bench/tb_h264_fetch.sv

// ==== verilog/fetch.sv ====
`timescale 1ns/1ps

module fetch
    import mb_geom_pkg::*, fetch_ctrl_pkg::*;
#(
    parameter int WIDTH_MB  = DEF_WIDTH_MB,
    parameter int HEIGHT_MB = DEF_HEIGHT_MB
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      en_i,
    // macroblock start towards the word source
    output logic      mb_start_o,
    output mb_coord_t mb_x_o,
    output mb_coord_t mb_y_o,
    // word FIFO
    input  logic      word_valid_i,
    input  mem_word_t word_i,
    output logic      word_pop_o,
    // intra stage handoff
    output logic      mb_valid_o,
    input  logic      mb_ack_i,
    input  row_idx_t  row_sel_i,
    output pix_row_t  row_o,
    output logic      frame_done_o
);

    localparam int WORDS_PER_ROW = MB_SIZE / PIX_PER_WORD;

    fetch_state_e state;
    fetch_state_e state_next;
    word_idx_t    word_cnt;
    row_idx_t     pos_x;
    row_idx_t     pos_y;
    logic         last_word;
    logic         last_mb;
    logic         mb_accept;
    pixel_t       luma [MB_SIZE][MB_SIZE];

    // pop whenever a word is waiting during the load
    assign word_pop_o = (state == FS_LD_Y) && word_valid_i;
    assign last_word  = (word_cnt == word_idx_t'(WORDS_PER_MB - 1));
    assign mb_accept  = (state == FS_WAIT_INTRA) && mb_valid_o && mb_ack_i;

    // bottom right macroblock of the frame
    assign last_mb = (mb_x_o == mb_coord_t'(WIDTH_MB - 1)) &&
                     (mb_y_o == mb_coord_t'(HEIGHT_MB - 1));

    // word count to matrix position
    assign pos_y = row_idx_t'(int'(word_cnt) / WORDS_PER_ROW);
    assign pos_x = row_idx_t'((int'(word_cnt) % WORDS_PER_ROW) * PIX_PER_WORD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FS_IDLE: begin
                if (en_i) begin
                    state_next = FS_LD_Y;
                end
            end
            // luma only, 64 words
            FS_LD_Y: begin
                if (word_pop_o && last_word) begin
                    state_next = FS_WAIT_INTRA;
                end
            end
            // hold the matrix until the intra stage takes it
            FS_WAIT_INTRA: begin
                if (mb_accept) begin
                    state_next = last_mb ? FS_DONE : FS_IDLE;
                end
            end
            // whole frame fetched, wait for reset
            FS_DONE: begin
                state_next = FS_DONE;
            end
            default: begin
                state_next = FS_IDLE;
            end
        endcase
    end

    // one cycle pulse on entry to the load
    always_ff @(posedge clk) begin
        if (rst) begin
            mb_start_o   <= 1'b0;
            mb_valid_o   <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            mb_start_o   <= (state != FS_LD_Y) && (state_next == FS_LD_Y);
            mb_valid_o   <= (state_next == FS_WAIT_INTRA);
            frame_done_o <= (state_next == FS_DONE);
        end
    end

    // words popped in the current macroblock
    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt <= '0;
        end else if (word_pop_o) begin
            // wraps to zero after the 64th word
            word_cnt <= word_cnt + word_idx_t'(1);
        end
    end

    // raster order step on ack
    always_ff @(posedge clk) begin
        if (rst) begin
            mb_x_o <= '0;
            mb_y_o <= '0;
        end else if (mb_accept) begin
            if (mb_x_o == mb_coord_t'(WIDTH_MB - 1)) begin
                mb_x_o <= '0;
                mb_y_o <= mb_y_o + mb_coord_t'(1);
            end else begin
                mb_x_o <= mb_x_o + mb_coord_t'(1);
            end
        end
    end

    // four adjacent pixels per popped word
    always_ff @(posedge clk) begin
        if (word_pop_o) begin
            for (int n = 0; n < PIX_PER_WORD; n++) begin
                luma[pos_y][pos_x + row_idx_t'(n)] <= word_i[n*PIXEL_W +: PIXEL_W];
            end
        end
    end

    // row readout for the intra stage
    always_comb begin
        for (int c = 0; c < MB_SIZE; c++) begin
            row_o[c*PIXEL_W +: PIXEL_W] = luma[row_sel_i][c];
        end
    end

    // held matrix stays untouched until the ack
    a_matrix_hold : assert property (@(posedge clk) disable iff (rst)
        mb_valid_o && $past(mb_valid_o) && $stable(row_sel_i) |-> $stable(row_o))
        else $error("luma matrix changed while handed to intra stage");

endmodule : fetch

// ==== verilog/fetch_ctrl_pkg.sv ====
package fetch_ctrl_pkg;

    // frame memory data and address widths
    parameter int MEM_WORD_W = 32;
    parameter int MEM_ADDR_W = 16;

    // index of a word inside one macroblock, 64 words
    parameter int WORD_IDX_W = 6;

    // fetch sequencer states, luma only
    typedef enum logic [1:0] {
        FS_IDLE       = 2'd0,
        FS_LD_Y       = 2'd1,
        FS_WAIT_INTRA = 2'd2,
        FS_DONE       = 2'd3
    } fetch_state_e;

    // one frame memory word, pixel column 4k+n in byte n
    typedef logic [MEM_WORD_W-1:0] mem_word_t;

    // word address into the frame memory
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // word position inside the current macroblock
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

endpackage : fetch_ctrl_pkg

// ==== verilog/h264_fetch_top.sv ====
`timescale 1ns/1ps

module h264_fetch_top
    import mb_geom_pkg::*, fetch_ctrl_pkg::*;
#(
    parameter int WIDTH_MB   = DEF_WIDTH_MB,
    parameter int HEIGHT_MB  = DEF_HEIGHT_MB,
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      en_i,
    // frame memory
    output logic      mem_req_o,
    output mem_addr_t mem_addr_o,
    input  mem_word_t mem_rdata_i,
    // intra stage
    output logic      mb_valid_o,
    output mb_coord_t mb_x_o,
    output mb_coord_t mb_y_o,
    input  logic      mb_ack_i,
    input  row_idx_t  row_sel_i,
    output pix_row_t  row_o,
    output logic      frame_done_o
);

    // fetch to source
    logic      mb_start;
    // source to FIFO
    logic      push;
    mem_word_t push_data;
    logic      credit_ret;
    // FIFO to fetch
    logic      word_valid;
    mem_word_t word;
    logic      word_pop;

    mb_word_source #(
        .WIDTH_MB   (WIDTH_MB),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) mb_word_source_i (
        .clk          (clk),
        .rst          (rst),
        .mb_start_i   (mb_start),
        .mb_x_i       (mb_x_o),
        .mb_y_i       (mb_y_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rdata_i  (mem_rdata_i),
        .push_o       (push),
        .push_data_o  (push_data),
        .credit_ret_i (credit_ret)
    );

    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) word_fifo_i (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (word_pop),
        .word_valid_o (word_valid),
        .word_o       (word),
        .credit_ret_o (credit_ret)
    );

    fetch #(
        .WIDTH_MB  (WIDTH_MB),
        .HEIGHT_MB (HEIGHT_MB)
    ) fetch_i (
        .clk          (clk),
        .rst          (rst),
        .en_i         (en_i),
        .mb_start_o   (mb_start),
        .mb_x_o       (mb_x_o),
        .mb_y_o       (mb_y_o),
        .word_valid_i (word_valid),
        .word_i       (word),
        .word_pop_o   (word_pop),
        .mb_valid_o   (mb_valid_o),
        .mb_ack_i     (mb_ack_i),
        .row_sel_i    (row_sel_i),
        .row_o        (row_o),
        .frame_done_o (frame_done_o)
    );

endmodule : h264_fetch_top

// ==== verilog/mb_geom_pkg.sv ====
package mb_geom_pkg;

    // macroblock side in luma pixels
    parameter int MB_SIZE = 16;

    // luma samples packed into one frame memory word
    parameter int PIX_PER_WORD = 4;

    // 16x16 luma, four pixels per word
    parameter int WORDS_PER_MB = (MB_SIZE * MB_SIZE) / PIX_PER_WORD;

    // frame size in macroblocks when the top is left at its defaults
    parameter int DEF_WIDTH_MB  = 4;
    parameter int DEF_HEIGHT_MB = 3;

    // field widths
    parameter int MB_COORD_W = 6;
    parameter int PIXEL_W    = 8;
    parameter int ROW_IDX_W  = $clog2(MB_SIZE);

    // macroblock x or y position in the frame
    typedef logic [MB_COORD_W-1:0] mb_coord_t;

    // one 8-bit luma sample
    typedef logic [PIXEL_W-1:0] pixel_t;

    // one matrix row, pixel 0 in the low byte
    typedef logic [MB_SIZE*PIXEL_W-1:0] pix_row_t;

    // row or column inside a macroblock
    typedef logic [ROW_IDX_W-1:0] row_idx_t;

endpackage : mb_geom_pkg

// ==== verilog/mb_word_source.sv ====
`timescale 1ns/1ps

module mb_word_source
    import mb_geom_pkg::*, fetch_ctrl_pkg::*;
#(
    parameter int WIDTH_MB   = DEF_WIDTH_MB,
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    // macroblock start from fetch
    input  logic      mb_start_i,
    input  mb_coord_t mb_x_i,
    input  mb_coord_t mb_y_i,
    // frame memory, one cycle read latency
    output logic      mem_req_o,
    output mem_addr_t mem_addr_o,
    input  mem_word_t mem_rdata_i,
    // into the word FIFO
    output logic      push_o,
    output mem_word_t push_data_o,
    input  logic      credit_ret_i
);

    // counter must hold the full depth
    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic              active;
    word_idx_t         rd_idx;
    mem_addr_t         mb_base;
    logic              issue;
    logic              last_read;

    // a read goes out only with a free FIFO slot reserved
    assign issue     = active && (credits != '0);
    assign last_read = (rd_idx == word_idx_t'(WORDS_PER_MB - 1));
    assign mem_req_o = issue;

    // word offset on top of the latched macroblock base
    assign mem_addr_o = mb_base + mem_addr_t'(rd_idx);

    // base address, only sampled at start
    always_ff @(posedge clk) begin
        if (mb_start_i) begin
            mb_base <= mem_addr_t'((int'(mb_y_i) * WIDTH_MB + int'(mb_x_i)) * WORDS_PER_MB);
        end
    end

    // read sequencer for the 64 words
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            rd_idx <= '0;
        end else if (mb_start_i) begin
            active <= 1'b1;
            rd_idx <= '0;
        end else if (issue) begin
            rd_idx <= rd_idx + word_idx_t'(1);
            // stop after the last word of the macroblock
            if (last_read) begin
                active <= 1'b0;
            end
        end
    end

    // credits, minus one per read, plus one per pop
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_W'(FIFO_DEPTH);
        end else begin
            case ({issue, credit_ret_i})
                2'b10:   credits <= credits - CRED_W'(1);
                2'b01:   credits <= credits + CRED_W'(1);
                default: credits <= credits;
            endcase
        end
    end

    // read data shows up one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            push_o <= 1'b0;
        end else begin
            push_o <= issue;
        end
    end

    assign push_data_o = mem_rdata_i;

    // returned credits never overfill the counter
    a_credit_max : assert property (@(posedge clk) disable iff (rst)
        credits <= CRED_W'(FIFO_DEPTH))
        else $error("credit count above FIFO depth");

    // a new macroblock only once the previous one is fully read back
    a_start_idle : assert property (@(posedge clk) disable iff (rst)
        mb_start_i |-> !active && !push_o)
        else $error("macroblock start with reads outstanding");

endmodule : mb_word_source

// ==== verilog/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo
    import fetch_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    // write side, from the word source
    input  logic      push_i,
    input  mem_word_t push_data_i,
    // read side, to fetch
    input  logic      pop_i,
    output logic      word_valid_o,
    output mem_word_t word_o,
    // one credit back per popped word
    output logic      credit_ret_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    mem_word_t         buf_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;

    assign full         = (count == CNT_W'(FIFO_DEPTH));
    assign word_valid_o = (count != '0);
    // head word, read in the same cycle as the pop
    assign word_o       = buf_mem[rd_ptr];

    // storage, no reset on data
    always_ff @(posedge clk) begin
        if (push_i) begin
            buf_mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push_i, pop_i})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // credit pulse trails the pop by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_ret_o <= 1'b0;
        end else begin
            credit_ret_o <= pop_i;
        end
    end

    // source credits must keep the buffer from overflowing
    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        push_i |-> !full)
        else $error("push into full word FIFO");

    // fetch pops only a valid head word
    a_no_underflow : assert property (@(posedge clk) disable iff (rst)
        pop_i |-> word_valid_o)
        else $error("pop from empty word FIFO");

endmodule : word_fifo
